// File: common/tomasulo_pkg.sv
// --------------------
// Shared widths, counts and vector types
// Opcode class tests for dispatch
// --------------------
`default_nettype none

package tomasulo_pkg;

  // Data path
  localparam int WORD_W = 32;
  typedef logic [WORD_W-1:0] word_t;

  // Architectural registers
  localparam int REG_N = 32;
  typedef logic [$clog2(REG_N)-1:0] reg_t;

  // Result tags handed out at dispatch
  localparam int TAG_N = 8;
  typedef logic [$clog2(TAG_N)-1:0] tag_t;

  // Reorder buffer
  localparam int ROB_N = 8;
  typedef logic [$clog2(ROB_N)-1:0] robid_t;

  // Opcode, class in the two top bits
  typedef logic [3:0] op_t;

  // Stations 0,1 arithmetic, 2,3 logic, 4 multiply
  localparam int RS_N = 5;
  typedef logic [RS_N-1:0] rs_vec_t;

  // Entries per station
  localparam int ARITH_RS_N = 2;
  localparam int LOGIC_RS_N = 2;
  localparam int MPY_RS_N   = 1;
  typedef logic [1:0] crdt_t;

  // Classes 00 and 01
  function automatic logic is_arith(op_t op);
    return (op[3] == 1'b0);
  endfunction

  // Class 10
  function automatic logic is_logic(op_t op);
    return (op[3:2] == 2'b10);
  endfunction

  // Class 11
  function automatic logic is_mpy(op_t op);
    return (op[3:2] == 2'b11);
  endfunction

endpackage

`default_nettype wire

// File: dispatch/dispatch_ctrl.sv
// --------------------
// Dispatch stall, station pick, record
// --------------------
`default_nettype none

module dispatch_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 inst_vld,
  input  tomasulo_pkg::op_t         inst_op,
  input  tomasulo_pkg::reg_t        inst_wa,
  input  wire logic                 wa_busy,
  input  wire logic                 tags_empty,
  input  wire logic                 rob_full,
  input  tomasulo_pkg::rs_vec_t     navail,
  input  tomasulo_pkg::tag_t        alloc_tag,
  input  tomasulo_pkg::robid_t      alloc_robid,
  input  tomasulo_pkg::word_t       src0,
  input  tomasulo_pkg::word_t       src1,
  input  wire logic                 src0_busy,
  input  wire logic                 src1_busy,
  output logic                      dis_fire,
  output tomasulo_pkg::rs_vec_t     dis_sel,
  output tomasulo_pkg::rs_vec_t     dis_vld,
  output tomasulo_pkg::op_t         dis_op,
  output tomasulo_pkg::tag_t        dis_tag,
  output tomasulo_pkg::robid_t      dis_robid,
  output tomasulo_pkg::reg_t        dis_wa,
  output logic                      dis_busy0,
  output logic                      dis_busy1,
  output tomasulo_pkg::word_t       dis_src0,
  output tomasulo_pkg::word_t       dis_src1
);
  import tomasulo_pkg::*;

  logic can_go;

  // WAW on the destination, no tag, or no buffer slot holds the instruction
  assign can_go = inst_vld & ~(wa_busy | tags_empty | rob_full);

  // Lower station of the class first, upper one only when the lower is out
  always_comb
  begin
    dis_sel = '0;
    if (can_go)
    begin
      if (is_arith(inst_op))
      begin
        if (!navail[0])
          dis_sel[0] = 1'b1;
        else if (!navail[1])
          dis_sel[1] = 1'b1;
      end
      else if (is_logic(inst_op))
      begin
        if (!navail[2])
          dis_sel[2] = 1'b1;
        else if (!navail[3])
          dis_sel[3] = 1'b1;
      end
      else if (!navail[4])
      begin
        // Single multiply station
        dis_sel[4] = 1'b1;
      end
    end
  end

  // Accept only once a station is picked
  assign dis_fire = |dis_sel;

  // One-cycle station strobe
  always_ff @(posedge clk)
  begin
    if (rst)
      dis_vld <= '0;
    else
      dis_vld <= dis_sel;
  end

  // Payload only moves on an accepted instruction
  always_ff @(posedge clk)
  begin
    if (dis_fire)
    begin
      dis_op    <= inst_op;
      dis_tag   <= alloc_tag;
      dis_robid <= alloc_robid;
      dis_wa    <= inst_wa;
      dis_busy0 <= src0_busy;
      dis_busy1 <= src1_busy;
      dis_src0  <= src0;
      dis_src1  <= src1;
    end
  end

endmodule

`default_nettype wire

// File: dispatch/rs_credit.sv
// --------------------
// Station credit counters
// --------------------
`default_nettype none

module rs_credit (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  tomasulo_pkg::rs_vec_t     dis_sel,
  input  tomasulo_pkg::rs_vec_t     iss_vld,
  output tomasulo_pkg::rs_vec_t     navail
);
  import tomasulo_pkg::*;

  crdt_t crdt [RS_N];
  crdt_t crdt_nxt [RS_N];

  // Depth of station i
  function automatic crdt_t rs_depth(int i);
    if (i < 2)
      return crdt_t'(ARITH_RS_N);
    else if (i < 4)
      return crdt_t'(LOGIC_RS_N);
    else
      return crdt_t'(MPY_RS_N);
  endfunction

  // Dispatch takes one, issue gives one back, both together cancel
  always_comb
  begin
    for (int i = 0; i < RS_N; i++)
    begin
      case ({dis_sel[i], iss_vld[i]})
        2'b10:   crdt_nxt[i] = crdt[i] - crdt_t'(1);
        2'b01:   crdt_nxt[i] = crdt[i] + crdt_t'(1);
        default: crdt_nxt[i] = crdt[i];
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < RS_N; i++)
    begin
      if (rst)
      begin
        crdt[i]   <= rs_depth(i);
        navail[i] <= 1'b0;
      end
      else
      begin
        crdt[i]   <= crdt_nxt[i];
        // Flag follows the updated count
        navail[i] <= (crdt_nxt[i] == '0);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/tag_free_list.sv
// --------------------
// Result tag free list
// --------------------
`default_nettype none

module tag_free_list (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 dis_fire,
  input  wire logic                 cdb_vld,
  input  tomasulo_pkg::tag_t        cdb_tag,
  output tomasulo_pkg::tag_t        alloc_tag,
  output logic                      tags_empty
);
  import tomasulo_pkg::*;

  logic [TAG_N-1:0] in_use;

  // Scan down so the lowest free tag wins
  always_comb
  begin
    alloc_tag = '0;
    for (int i = TAG_N - 1; i >= 0; i--)
    begin
      if (!in_use[i])
        alloc_tag = tag_t'(i);
    end
  end

  assign tags_empty = &in_use;

  // Released tag and allocated tag are never the same one
  always_ff @(posedge clk)
  begin
    if (rst)
      in_use <= '0;
    else
    begin
      if (cdb_vld)
        in_use[cdb_tag] <= 1'b0;
      if (dis_fire)
        in_use[alloc_tag] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/operand_file.sv
// --------------------
// Register values, tags, busy bits
// Two source read ports with CDB bypass
// --------------------
`default_nettype none

module operand_file (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 dis_fire,
  input  tomasulo_pkg::reg_t        inst_ra0,
  input  tomasulo_pkg::reg_t        inst_ra1,
  input  tomasulo_pkg::reg_t        inst_wa,
  input  tomasulo_pkg::tag_t        alloc_tag,
  input  wire logic                 cdb_vld,
  input  tomasulo_pkg::reg_t        cdb_wa,
  input  tomasulo_pkg::word_t       cdb_wdata,
  output logic                      wa_busy,
  output tomasulo_pkg::word_t       src0,
  output tomasulo_pkg::word_t       src1,
  output logic                      src0_busy,
  output logic                      src1_busy
);
  import tomasulo_pkg::*;

  word_t            vals [REG_N];
  tag_t             tags [REG_N];
  logic [REG_N-1:0] busy;

  reg_t  ra [2];
  word_t rd [2];
  logic  rd_busy [2];

  // Read ports
  always_comb
  begin
    ra[0] = inst_ra0;
    ra[1] = inst_ra1;
    for (int p = 0; p < 2; p++)
    begin
      if (busy[ra[p]] && cdb_vld && (cdb_wa == ra[p]))
      begin
        // Result lands this cycle, take it straight off the bus
        rd[p]      = cdb_wdata;
        rd_busy[p] = 1'b0;
      end
      else if (busy[ra[p]])
      begin
        // Still pending, pass the producer tag in the low bits
        rd[p]      = word_t'(tags[ra[p]]);
        rd_busy[p] = 1'b1;
      end
      else
      begin
        rd[p]      = vals[ra[p]];
        rd_busy[p] = 1'b0;
      end
    end
  end

  assign src0      = rd[0];
  assign src1      = rd[1];
  assign src0_busy = rd_busy[0];
  assign src1_busy = rd_busy[1];

  // Outstanding writer on the destination
  assign wa_busy = busy[inst_wa];

  // Busy bits; dispatch never targets the register the CDB clears
  always_ff @(posedge clk)
  begin
    if (rst)
      busy <= '0;
    else
    begin
      if (cdb_vld)
        busy[cdb_wa] <= 1'b0;
      if (dis_fire)
        busy[inst_wa] <= 1'b1;
    end
  end

  // Architectural values start at zero
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int r = 0; r < REG_N; r++)
        vals[r] <= '0;
    end
    else if (cdb_vld)
      vals[cdb_wa] <= cdb_wdata;
  end

  // Producer tag per register
  always_ff @(posedge clk)
  begin
    if (dis_fire)
      tags[inst_wa] <= alloc_tag;
  end

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
// --------------------
// In-order retire buffer
// --------------------
`default_nettype none

module reorder_buffer (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 dis_fire,
  input  tomasulo_pkg::reg_t        inst_wa,
  input  wire logic                 cdb_vld,
  input  tomasulo_pkg::robid_t      cdb_robid,
  input  tomasulo_pkg::word_t       cdb_wdata,
  output tomasulo_pkg::robid_t      alloc_robid,
  output logic                      rob_full,
  output logic                      out_vld,
  output tomasulo_pkg::reg_t        out_wa,
  output tomasulo_pkg::word_t       out_wdata
);
  import tomasulo_pkg::*;

  reg_t             ent_wa [ROB_N];
  word_t            ent_data [ROB_N];
  logic [ROB_N-1:0] done;

  robid_t                     head;
  robid_t                     tail;
  logic [$clog2(ROB_N+1)-1:0] count;
  logic                       retire;

  assign alloc_robid = tail;
  assign rob_full    = (count == ROB_N);

  // Head leaves as soon as its result is in
  assign retire = done[head];

  // Pointers, occupancy and completion flags
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end
    else
    begin
      if (dis_fire)
        tail <= tail + robid_t'(1);
      if (retire)
      begin
        head       <= head + robid_t'(1);
        done[head] <= 1'b0;
      end
      if (cdb_vld)
        done[cdb_robid] <= 1'b1;
      count <= count + dis_fire - retire;
    end
  end

  // Entry payload
  always_ff @(posedge clk)
  begin
    if (dis_fire)
      ent_wa[tail] <= inst_wa;
    if (cdb_vld)
      ent_data[cdb_robid] <= cdb_wdata;
  end

  // Retire port
  always_ff @(posedge clk)
  begin
    if (rst)
      out_vld <= 1'b0;
    else
      out_vld <= retire;
  end

  always_ff @(posedge clk)
  begin
    if (retire)
    begin
      out_wa    <= ent_wa[head];
      out_wdata <= ent_data[head];
    end
  end

endmodule

`default_nettype wire

// File: source/tomasulo_dispatcher.sv
// --------------------
// Dispatch stage top
// --------------------
`default_nettype none

module tomasulo_dispatcher (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // Instruction queue head
  input  wire logic                 inst_vld,
  input  tomasulo_pkg::op_t         inst_op,
  input  tomasulo_pkg::reg_t        inst_ra0,
  input  tomasulo_pkg::reg_t        inst_ra1,
  input  tomasulo_pkg::reg_t        inst_wa,
  output logic                      inst_adv,
  // Common data bus
  input  wire logic                 cdb_vld,
  input  tomasulo_pkg::reg_t        cdb_wa,
  input  tomasulo_pkg::tag_t        cdb_tag,
  input  tomasulo_pkg::robid_t      cdb_robid,
  input  tomasulo_pkg::word_t       cdb_wdata,
  // Station issue strobes
  input  tomasulo_pkg::rs_vec_t     iss_vld,
  // Dispatch record
  output tomasulo_pkg::rs_vec_t     dis_vld,
  output tomasulo_pkg::op_t         dis_op,
  output tomasulo_pkg::tag_t        dis_tag,
  output tomasulo_pkg::robid_t      dis_robid,
  output tomasulo_pkg::reg_t        dis_wa,
  output logic                      dis_busy0,
  output logic                      dis_busy1,
  output tomasulo_pkg::word_t       dis_src0,
  output tomasulo_pkg::word_t       dis_src1,
  // Retire
  output logic                      out_vld,
  output tomasulo_pkg::reg_t        out_wa,
  output tomasulo_pkg::word_t       out_wdata
);
  import tomasulo_pkg::*;

  logic    dis_fire;
  rs_vec_t dis_sel;
  rs_vec_t navail;
  tag_t    alloc_tag;
  logic    tags_empty;
  robid_t  alloc_robid;
  logic    rob_full;
  logic    wa_busy;
  word_t   src0;
  word_t   src1;
  logic    src0_busy;
  logic    src1_busy;

  // Queue pops exactly when the instruction goes
  assign inst_adv = dis_fire;

  dispatch_ctrl i_dispatch_ctrl (
    .clk         (clk),
    .rst         (rst),
    .inst_vld    (inst_vld),
    .inst_op     (inst_op),
    .inst_wa     (inst_wa),
    .wa_busy     (wa_busy),
    .tags_empty  (tags_empty),
    .rob_full    (rob_full),
    .navail      (navail),
    .alloc_tag   (alloc_tag),
    .alloc_robid (alloc_robid),
    .src0        (src0),
    .src1        (src1),
    .src0_busy   (src0_busy),
    .src1_busy   (src1_busy),
    .dis_fire    (dis_fire),
    .dis_sel     (dis_sel),
    .dis_vld     (dis_vld),
    .dis_op      (dis_op),
    .dis_tag     (dis_tag),
    .dis_robid   (dis_robid),
    .dis_wa      (dis_wa),
    .dis_busy0   (dis_busy0),
    .dis_busy1   (dis_busy1),
    .dis_src0    (dis_src0),
    .dis_src1    (dis_src1)
  );

  rs_credit i_rs_credit (
    .clk     (clk),
    .rst     (rst),
    .dis_sel (dis_sel),
    .iss_vld (iss_vld),
    .navail  (navail)
  );

  tag_free_list i_tag_free_list (
    .clk        (clk),
    .rst        (rst),
    .dis_fire   (dis_fire),
    .cdb_vld    (cdb_vld),
    .cdb_tag    (cdb_tag),
    .alloc_tag  (alloc_tag),
    .tags_empty (tags_empty)
  );

  operand_file i_operand_file (
    .clk       (clk),
    .rst       (rst),
    .dis_fire  (dis_fire),
    .inst_ra0  (inst_ra0),
    .inst_ra1  (inst_ra1),
    .inst_wa   (inst_wa),
    .alloc_tag (alloc_tag),
    .cdb_vld   (cdb_vld),
    .cdb_wa    (cdb_wa),
    .cdb_wdata (cdb_wdata),
    .wa_busy   (wa_busy),
    .src0      (src0),
    .src1      (src1),
    .src0_busy (src0_busy),
    .src1_busy (src1_busy)
  );

  reorder_buffer i_reorder_buffer (
    .clk         (clk),
    .rst         (rst),
    .dis_fire    (dis_fire),
    .inst_wa     (inst_wa),
    .cdb_vld     (cdb_vld),
    .cdb_robid   (cdb_robid),
    .cdb_wdata   (cdb_wdata),
    .alloc_robid (alloc_robid),
    .rob_full    (rob_full),
    .out_vld     (out_vld),
    .out_wa      (out_wa),
    .out_wdata   (out_wdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_tomasulo_dispatcher.sv
// --------------------
// Testbench for the dispatch stage
// Random program, station and FU emulation, in-order model
// --------------------
`default_nettype none

module tb_tomasulo_dispatcher;
  timeunit 1ns;
  timeprecision 100ps;
  import tomasulo_pkg::*;

  localparam int N_INST = 2000;
  // Worst case about 40 cycles per instruction
  localparam int LIMIT  = N_INST * 40;

  logic    clk;
  logic    rst;
  logic    inst_vld;
  op_t     inst_op;
  reg_t    inst_ra0;
  reg_t    inst_ra1;
  reg_t    inst_wa;
  logic    inst_adv;
  logic    cdb_vld;
  reg_t    cdb_wa;
  tag_t    cdb_tag;
  robid_t  cdb_robid;
  word_t   cdb_wdata;
  rs_vec_t iss_vld;
  rs_vec_t dis_vld;
  op_t     dis_op;
  tag_t    dis_tag;
  robid_t  dis_robid;
  reg_t    dis_wa;
  logic    dis_busy0;
  logic    dis_busy1;
  word_t   dis_src0;
  word_t   dis_src1;
  logic    out_vld;
  reg_t    out_wa;
  word_t   out_wdata;

  // Program and its in-order results
  op_t   p_op [N_INST];
  reg_t  p_ra0 [N_INST];
  reg_t  p_ra1 [N_INST];
  reg_t  p_wa [N_INST];
  word_t g_src0 [N_INST];
  word_t g_src1 [N_INST];
  word_t g_res [N_INST];

  // Station entries, indexed by program order
  op_t    e_op [N_INST];
  tag_t   e_tag [N_INST];
  robid_t e_robid [N_INST];
  reg_t   e_wa [N_INST];
  logic   e_busy0 [N_INST];
  logic   e_busy1 [N_INST];
  word_t  e_src0 [N_INST];
  word_t  e_src1 [N_INST];
  word_t  e_res [N_INST];
  int     e_rs [N_INST];
  int     e_delay [N_INST];
  int     waiting [$];
  int     finished [$];

  // Model of busy registers, tags in use and station credits
  logic [REG_N-1:0] m_busy;
  tag_t             m_tag [REG_N];
  logic [TAG_N-1:0] m_used;
  int               m_crdt [RS_N];

  // Record expected on the next cycle
  logic    x_pend;
  int      x_idx;
  rs_vec_t x_sel;
  tag_t    x_tag;
  robid_t  x_robid;
  logic    x_b0;
  logic    x_b1;
  word_t   x_s0;
  word_t   x_s1;

  int          pc;
  int          dis_cnt;
  int          ret_idx;
  int          cycle;
  int          errors;
  int          checks;

  tomasulo_dispatcher i_tomasulo_dispatcher (
    .clk       (clk),
    .rst       (rst),
    .inst_vld  (inst_vld),
    .inst_op   (inst_op),
    .inst_ra0  (inst_ra0),
    .inst_ra1  (inst_ra1),
    .inst_wa   (inst_wa),
    .inst_adv  (inst_adv),
    .cdb_vld   (cdb_vld),
    .cdb_wa    (cdb_wa),
    .cdb_tag   (cdb_tag),
    .cdb_robid (cdb_robid),
    .cdb_wdata (cdb_wdata),
    .iss_vld   (iss_vld),
    .dis_vld   (dis_vld),
    .dis_op    (dis_op),
    .dis_tag   (dis_tag),
    .dis_robid (dis_robid),
    .dis_wa    (dis_wa),
    .dis_busy0 (dis_busy0),
    .dis_busy1 (dis_busy1),
    .dis_src0  (dis_src0),
    .dis_src1  (dis_src1),
    .out_vld   (out_vld),
    .out_wa    (out_wa),
    .out_wdata (out_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // First station of the opcode class
  function automatic int station_base(op_t op);
    if (op[3] == 1'b0)
      return 0;
    else if (op[2] == 1'b0)
      return 2;
    else
      return 4;
  endfunction

  function automatic int station_depth(int s);
    if (s < 2)
      return ARITH_RS_N;
    else if (s < 4)
      return LOGIC_RS_N;
    else
      return MPY_RS_N;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expv,
                             input logic [63:0] actv);
    checks++;
    if (expv !== actv)
    begin
      errors++;
      $display("Error %s: expected %0h, actual %0h (cycle %0d)", name, expv, actv, cycle);
    end
  endtask

  // Few registers so that hazards come often
  task automatic build_program();
    word_t gval [REG_N];
    for (int r = 0; r < REG_N; r++)
      gval[r] = '0;
    for (int i = 0; i < N_INST; i++)
    begin
      p_op[i]   = op_t'($urandom % 16);
      p_ra0[i]  = reg_t'($urandom % 8);
      p_ra1[i]  = reg_t'($urandom % 8);
      p_wa[i]   = reg_t'($urandom % 8);
      g_src0[i] = gval[p_ra0[i]];
      g_src1[i] = gval[p_ra1[i]];
      g_res[i]  = (word_t'(p_op[i]) ^ g_src0[i]) + g_src1[i];
      gval[p_wa[i]] = g_res[i];
    end
  endtask

  task automatic check_retire();
    if (out_vld)
    begin
      if (ret_idx < N_INST)
      begin
        check_value("retire_wa", p_wa[ret_idx], out_wa);
        check_value("retire_wdata", g_res[ret_idx], out_wdata);
      end
      else
      begin
        errors++;
        $display("Retire pulse seen after the last instruction had retired");
      end
      ret_idx++;
    end
  endtask

  // Compare the registered record and hand it to its station
  task automatic check_record();
    int st;
    int occ;
    if (!x_pend)
    begin
      check_value("dis_vld_idle", '0, dis_vld);
      return;
    end
    check_value("dis_vld", x_sel, dis_vld);
    check_value("dis_op", p_op[x_idx], dis_op);
    check_value("dis_tag", x_tag, dis_tag);
    check_value("dis_robid", x_robid, dis_robid);
    check_value("dis_wa", p_wa[x_idx], dis_wa);
    check_value("dis_busy0", x_b0, dis_busy0);
    check_value("dis_src0", x_s0, dis_src0);
    check_value("dis_busy1", x_b1, dis_busy1);
    check_value("dis_src1", x_s1, dis_src1);
    x_pend = 1'b0;
    st = -1;
    for (int s = 0; s < RS_N; s++)
      if (dis_vld[s])
        st = s;
    if (st < 0)
      return;
    e_op[x_idx]    = dis_op;
    e_tag[x_idx]   = dis_tag;
    e_robid[x_idx] = dis_robid;
    e_wa[x_idx]    = dis_wa;
    e_busy0[x_idx] = dis_busy0;
    e_busy1[x_idx] = dis_busy1;
    e_src0[x_idx]  = dis_src0;
    e_src1[x_idx]  = dis_src1;
    e_rs[x_idx]    = st;
    e_delay[x_idx] = $urandom % 4;
    waiting.push_back(x_idx);
    occ = 0;
    foreach (waiting[i])
      if (e_rs[waiting[i]] == st)
        occ++;
    if (occ > station_depth(st))
    begin
      errors++;
      $display("Station %0d holds %0d entries, more than its depth", st, occ);
    end
  endtask

  // Expected acceptance and record for the presented instruction
  task automatic accept_instruction();
    int   base;
    int   st;
    int   ftag;
    logic go;
    base = station_base(inst_op);
    st   = -1;
    if (m_crdt[base] > 0)
      st = base;
    else if (base < 4)
    begin
      if (m_crdt[base + 1] > 0)
        st = base + 1;
    end
    ftag = -1;
    for (int t = 0; t < TAG_N; t++)
      if (ftag < 0 && !m_used[t])
        ftag = t;
    go = !m_busy[inst_wa] && (ftag >= 0) && (dis_cnt - ret_idx < ROB_N) && (st >= 0);
    check_value("inst_adv", go, inst_adv);
    if (!inst_adv)
      return;
    check_value("waw_stall", 1'b0, m_busy[inst_wa]);
    x_pend  = 1'b1;
    x_idx   = pc;
    x_sel   = '0;
    if (st >= 0)
      x_sel[st] = 1'b1;
    x_tag   = tag_t'(ftag);
    x_robid = robid_t'(dis_cnt);
    // Bypass when the pending producer is on the bus this cycle
    x_b0 = m_busy[inst_ra0] && !(cdb_vld && cdb_wa == inst_ra0);
    x_b1 = m_busy[inst_ra1] && !(cdb_vld && cdb_wa == inst_ra1);
    x_s0 = x_b0 ? word_t'(m_tag[inst_ra0]) : g_src0[pc];
    x_s1 = x_b1 ? word_t'(m_tag[inst_ra1]) : g_src1[pc];
    m_busy[inst_wa] = 1'b1;
    m_tag[inst_wa]  = x_tag;
    m_used[x_tag]   = 1'b1;
    if (st >= 0)
      m_crdt[st]--;
    dis_cnt++;
    pc++;
  endtask

  // Operand snoop, issue and CDB return
  task automatic run_stations();
    rs_vec_t iss;
    int      idx;
    int      k;
    iss = '0;
    if (cdb_vld)
    begin
      foreach (waiting[i])
      begin
        idx = waiting[i];
        if (e_busy0[idx] && tag_t'(e_src0[idx]) == cdb_tag)
        begin
          e_src0[idx]  = cdb_wdata;
          e_busy0[idx] = 1'b0;
        end
        if (e_busy1[idx] && tag_t'(e_src1[idx]) == cdb_tag)
        begin
          e_src1[idx]  = cdb_wdata;
          e_busy1[idx] = 1'b0;
        end
      end
    end
    // Oldest ready entry per station goes
    k = 0;
    while (k < waiting.size())
    begin
      idx = waiting[k];
      if (e_delay[idx] > 0)
      begin
        e_delay[idx]--;
        k++;
      end
      else if (!iss[e_rs[idx]] && !e_busy0[idx] && !e_busy1[idx])
      begin
        iss[e_rs[idx]] = 1'b1;
        e_res[idx] = (word_t'(e_op[idx]) ^ e_src0[idx]) + e_src1[idx];
        finished.push_back(idx);
        waiting.delete(k);
      end
      else
        k++;
    end
    iss_vld <= iss;
    // One result per cycle, any finished entry
    if (finished.size() > 0 && ($urandom % 4) != 0)
    begin
      k   = $urandom % finished.size();
      idx = finished[k];
      finished.delete(k);
      cdb_vld   <= 1'b1;
      cdb_wa    <= e_wa[idx];
      cdb_tag   <= e_tag[idx];
      cdb_robid <= e_robid[idx];
      cdb_wdata <= e_res[idx];
    end
    else
      cdb_vld <= 1'b0;
  endtask

  // Next instruction once the current one is taken, with random gaps
  task automatic feed_instruction();
    if (inst_adv || !inst_vld)
    begin
      if (pc < N_INST && ($urandom % 8) != 0)
      begin
        inst_vld <= 1'b1;
        inst_op  <= p_op[pc];
        inst_ra0 <= p_ra0[pc];
        inst_ra1 <= p_ra1[pc];
        inst_wa  <= p_wa[pc];
      end
      else
        inst_vld <= 1'b0;
    end
  endtask

  // Values seen at the edge belong to the cycle that just ended
  task automatic step_cycle();
    check_retire();
    check_record();
    if (inst_vld)
      accept_instruction();
    for (int s = 0; s < RS_N; s++)
      if (iss_vld[s])
        m_crdt[s]++;
    if (cdb_vld)
    begin
      m_used[cdb_tag] = 1'b0;
      m_busy[cdb_wa]  = 1'b0;
    end
    run_stations();
    feed_instruction();
  endtask

  initial
  begin
    void'($urandom(32'h21dde834));
    rst       <= 1'b1;
    inst_vld  <= 1'b0;
    inst_op   <= '0;
    inst_ra0  <= '0;
    inst_ra1  <= '0;
    inst_wa   <= '0;
    cdb_vld   <= 1'b0;
    cdb_wa    <= '0;
    cdb_tag   <= '0;
    cdb_robid <= '0;
    cdb_wdata <= '0;
    iss_vld   <= '0;
    m_busy    = '0;
    m_used    = '0;
    x_pend    = 1'b0;
    pc        = 0;
    dis_cnt   = 0;
    ret_idx   = 0;
    cycle     = 0;
    errors    = 0;
    checks    = 0;
    for (int s = 0; s < RS_N; s++)
      m_crdt[s] = station_depth(s);
    build_program();
    for (int c = 0; c < 10; c++)
    begin
      @(posedge clk);
      if (c > 0)
      begin
        check_value("reset_dis_vld", '0, dis_vld);
        check_value("reset_out_vld", 1'b0, out_vld);
      end
    end
    rst <= 1'b0;
    while (ret_idx < N_INST && cycle < LIMIT)
    begin
      @(posedge clk);
      cycle++;
      step_cycle();
    end
    if (ret_idx < N_INST)
    begin
      errors++;
      $display("Timeout at cycle %0d with %0d of %0d instructions retired",
               cycle, ret_idx, N_INST);
    end
    else
    begin
      // Drained, no further dispatch or retire may show up
      for (int c = 0; c < 16; c++)
      begin
        @(posedge clk);
        cycle++;
        step_cycle();
      end
    end
    $display("Checks run: %0d, errors: %0d, cycles: %0d", checks, errors, cycle);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
common/tomasulo_pkg.sv
dispatch/dispatch_ctrl.sv
dispatch/rs_credit.sv
source/tag_free_list.sv
source/operand_file.sv
source/reorder_buffer.sv
source/tomasulo_dispatcher.sv
dv/tb_tomasulo_dispatcher.sv

// File: Bender.yml
package:
  name: tomasulo_dispatcher

sources:
  - common/tomasulo_pkg.sv
  - dispatch/dispatch_ctrl.sv
  - dispatch/rs_credit.sv
  - source/tag_free_list.sv
  - source/operand_file.sv
  - source/reorder_buffer.sv
  - source/tomasulo_dispatcher.sv
  - target: test
    files:
      - dv/tb_tomasulo_dispatcher.sv
